// File: source/noc_geom_pkg.sv
package noc_geom_pkg;

    localparam int NX  = 4;                 // routers along x
    localparam int NY  = 4;                 // routers along y
    localparam int NL  = 2;                 // endpoints per router

    localparam int RXW = $clog2(NX);
    localparam int RYW = $clog2(NY);
    localparam int RLW = $clog2(NL);

    localparam int RAW = RYW + RXW;         // router address width
    localparam int EAW = RLW + RYW + RXW;   // endpoint address width

    typedef logic [RXW-1:0] coord_x_t;
    typedef logic [RYW-1:0] coord_y_t;
    typedef logic [RLW-1:0] local_idx_t;
    typedef logic [RAW-1:0] r_addr_t;       // {y, x}
    typedef logic [EAW-1:0] e_addr_t;       // {l, y, x}

    function automatic coord_x_t router_x(r_addr_t addr);
        return addr[RXW-1:0];
    endfunction

    function automatic coord_y_t router_y(r_addr_t addr);
        return addr[RAW-1:RXW];
    endfunction

    function automatic coord_x_t endp_x(e_addr_t addr);
        return addr[RXW-1:0];
    endfunction

    function automatic coord_y_t endp_y(e_addr_t addr);
        return addr[RXW+RYW-1:RXW];
    endfunction

    // local index sits above the router coordinates
    function automatic local_idx_t endp_l(e_addr_t addr);
        return addr[EAW-1:RXW+RYW];
    endfunction

endpackage

// File: source/route_pkg.sv
package route_pkg;

    import noc_geom_pkg::*;

    localparam int P  = 6;                  // 4 mesh ports plus 2 locals
    localparam int PW = $clog2(P);

    typedef enum logic [PW-1:0] {
        PORT_LOCAL0 = 3'd0,
        PORT_EAST   = 3'd1,
        PORT_NORTH  = 3'd2,
        PORT_WEST   = 3'd3,
        PORT_SOUTH  = 3'd4,
        PORT_LOCAL1 = 3'd5
    } port_e;

    // header from the local network interface
    typedef struct packed {
        e_addr_t dest_addr;
    } inject_hdr_t;

    // header from an input buffer, port chosen upstream
    typedef struct packed {
        e_addr_t dest_addr;
        port_e   destport;
    } transit_hdr_t;

    typedef struct packed {
        e_addr_t dest_addr;
        port_e   port;
    } routed_hdr_t;

    function automatic logic is_local(port_e p);
        return (p == PORT_LOCAL0) || (p == PORT_LOCAL1);
    endfunction

endpackage

// File: source/xy_route_decide.sv
`timescale 1ns/1ps

module xy_route_decide
    import noc_geom_pkg::*;
    import route_pkg::*;
(
    input  coord_x_t   cur_x,
    input  coord_y_t   cur_y,
    input  coord_x_t   dest_x,
    input  coord_y_t   dest_y,
    input  local_idx_t dest_l,
    output port_e      port
);

    logic go_east;
    logic go_west;
    logic go_north;
    logic go_south;

    // y grows towards the south edge
    assign go_east  = (dest_x > cur_x);
    assign go_west  = (dest_x < cur_x);
    assign go_north = (dest_y < cur_y);
    assign go_south = (dest_y > cur_y);

    always_comb begin
        if (go_east) begin
            port = PORT_EAST;
        end else if (go_west) begin
            port = PORT_WEST;
        end else if (go_north) begin          // x resolved, now y
            port = PORT_NORTH;
        end else if (go_south) begin
            port = PORT_SOUTH;
        end else if (dest_l == local_idx_t'(0)) begin
            port = PORT_LOCAL0;               // arrived
        end else begin
            port = PORT_LOCAL1;
        end
    end

endmodule

// File: source/next_router_select.sv
`timescale 1ns/1ps

module next_router_select
    import noc_geom_pkg::*;
    import route_pkg::*;
#(
    parameter coord_x_t CUR_X = '0,
    parameter coord_y_t CUR_Y = '0
) (
    input  port_e    destport,
    output coord_x_t next_x,
    output coord_y_t next_y
);

    // neighbor coordinates, fixed per router instance
    localparam coord_x_t EAST_X  = CUR_X + coord_x_t'(1);
    localparam coord_x_t WEST_X  = CUR_X - coord_x_t'(1);
    localparam coord_y_t NORTH_Y = CUR_Y - coord_y_t'(1);
    localparam coord_y_t SOUTH_Y = CUR_Y + coord_y_t'(1);

    always_comb begin
        next_x = CUR_X;                       // locals stay here
        next_y = CUR_Y;
        case (destport)
            PORT_EAST: begin
                next_x = EAST_X;
            end
            PORT_WEST: begin
                next_x = WEST_X;
            end
            PORT_NORTH: begin
                next_y = NORTH_Y;
            end
            PORT_SOUTH: begin
                next_y = SOUTH_Y;
            end
            default: begin
                next_x = CUR_X;
                next_y = CUR_Y;
            end
        endcase
    end

endmodule

// File: source/look_ahead_route.sv
`timescale 1ns/1ps

module look_ahead_route
    import noc_geom_pkg::*;
    import route_pkg::*;
#(
    parameter coord_x_t CUR_X = '0,
    parameter coord_y_t CUR_Y = '0
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  transit_hdr_t in_hdr,
    output logic         out_valid,
    output routed_hdr_t  out_hdr
);

    coord_x_t   dest_x;
    coord_y_t   dest_y;
    local_idx_t dest_l;
    coord_x_t   next_x;
    coord_y_t   next_y;
    port_e      next_port;
    port_e      lk_port;

    assign dest_x = endp_x(in_hdr.dest_addr);
    assign dest_y = endp_y(in_hdr.dest_addr);
    assign dest_l = endp_l(in_hdr.dest_addr);

    next_router_select #(
        .CUR_X(CUR_X),
        .CUR_Y(CUR_Y)
    ) i_next_router_select (
        .destport(in_hdr.destport),
        .next_x  (next_x),
        .next_y  (next_y)
    );

    // route as the downstream router would
    xy_route_decide i_xy_route_decide (
        .cur_x (next_x),
        .cur_y (next_y),
        .dest_x(dest_x),
        .dest_y(dest_y),
        .dest_l(dest_l),
        .port  (next_port)
    );

    // a local destport means the packet ejects here
    assign lk_port = is_local(in_hdr.destport) ? in_hdr.destport : next_port;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_hdr.dest_addr <= in_hdr.dest_addr;
            out_hdr.port      <= lk_port;
        end
    end

endmodule

// File: source/inject_route.sv
`timescale 1ns/1ps

module inject_route
    import noc_geom_pkg::*;
    import route_pkg::*;
#(
    parameter coord_x_t CUR_X = '0,
    parameter coord_y_t CUR_Y = '0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  inject_hdr_t in_hdr,
    output logic        out_valid,
    output routed_hdr_t out_hdr
);

    coord_x_t   dest_x;
    coord_y_t   dest_y;
    local_idx_t dest_l;
    port_e      cur_port;

    assign dest_x = endp_x(in_hdr.dest_addr);
    assign dest_y = endp_y(in_hdr.dest_addr);
    assign dest_l = endp_l(in_hdr.dest_addr);

    // conventional routing at this router
    xy_route_decide i_xy_route_decide (
        .cur_x (CUR_X),
        .cur_y (CUR_Y),
        .dest_x(dest_x),
        .dest_y(dest_y),
        .dest_l(dest_l),
        .port  (cur_port)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_hdr.dest_addr <= in_hdr.dest_addr;   // passes unchanged
            out_hdr.port      <= cur_port;
        end
    end

endmodule

// File: source/mesh_route_unit.sv
`timescale 1ns/1ps

module mesh_route_unit
    import noc_geom_pkg::*;
    import route_pkg::*;
#(
    parameter r_addr_t ROUTER_ADDR = '0
) (
    input  logic         clk,
    input  logic         reset,

    input  logic         inj_valid,       // from local network interface
    input  inject_hdr_t  inj_hdr,
    input  logic         trn_valid,       // from input buffer
    input  transit_hdr_t trn_hdr,

    output logic         inj_out_valid,
    output routed_hdr_t  inj_out_hdr,     // port at this router
    output logic         trn_out_valid,
    output routed_hdr_t  trn_out_hdr      // port at the next router
);

    localparam coord_x_t CUR_X = router_x(ROUTER_ADDR);
    localparam coord_y_t CUR_Y = router_y(ROUTER_ADDR);

    inject_route #(
        .CUR_X(CUR_X),
        .CUR_Y(CUR_Y)
    ) i_inject_route (
        .clk      (clk),
        .reset    (reset),
        .in_valid (inj_valid),
        .in_hdr   (inj_hdr),
        .out_valid(inj_out_valid),
        .out_hdr  (inj_out_hdr)
    );

    look_ahead_route #(
        .CUR_X(CUR_X),
        .CUR_Y(CUR_Y)
    ) i_look_ahead_route (
        .clk      (clk),
        .reset    (reset),
        .in_valid (trn_valid),
        .in_hdr   (trn_hdr),
        .out_valid(trn_out_valid),
        .out_hdr  (trn_out_hdr)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;                      // released after 5 rising edges
    end

endmodule

// File: testbench/mesh_route_unit_checker.sv
`timescale 1ns/1ps

module mesh_route_unit_checker
    import route_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        inj_valid,
    input logic        trn_valid,
    input logic        inj_out_valid,
    input routed_hdr_t inj_out_hdr,
    input logic        trn_out_valid,
    input routed_hdr_t trn_out_hdr
);

    // nothing leaves the unit in the first cycle after reset
    assert property (@(posedge clk) $fell(reset) |-> !inj_out_valid && !trn_out_valid)
        else $error("output valid high in the first cycle after reset");

    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> inj_out_valid == $past(inj_valid))
        else $error("inj_out_valid does not follow inj_valid by one cycle");

    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> trn_out_valid == $past(trn_valid))
        else $error("trn_out_valid does not follow trn_valid by one cycle");

    assert property (@(posedge clk) disable iff (reset)
        inj_out_valid |-> int'(inj_out_hdr.port) < P)
        else $error("inj_out_hdr.port out of range");

    assert property (@(posedge clk) disable iff (reset)
        trn_out_valid |-> int'(trn_out_hdr.port) < P)
        else $error("trn_out_hdr.port out of range");

endmodule

bind mesh_route_unit mesh_route_unit_checker i_checker (
    .clk          (clk),
    .reset        (reset),
    .inj_valid    (inj_valid),
    .trn_valid    (trn_valid),
    .inj_out_valid(inj_out_valid),
    .inj_out_hdr  (inj_out_hdr),
    .trn_out_valid(trn_out_valid),
    .trn_out_hdr  (trn_out_hdr)
);

// File: testbench/mesh_route_unit_tb.sv
`timescale 1ns/1ps

module mesh_route_unit_tb
    import noc_geom_pkg::*;
    import route_pkg::*;
();

    localparam int      CUR_X         = 1;
    localparam int      CUR_Y         = 2;
    localparam r_addr_t ROUTER_ADDR   = {coord_y_t'(CUR_Y), coord_x_t'(CUR_X)};
    localparam int      IDLE_CYCLES   = 4;      // quiet cycles after reset
    localparam int      NUM_CYCLES    = 2000;
    localparam int      RESET_TIMEOUT = 50;

    logic         clk;
    logic         reset;
    logic         inj_valid;
    inject_hdr_t  inj_hdr;
    logic         trn_valid;
    transit_hdr_t trn_hdr;
    logic         inj_out_valid;
    routed_hdr_t  inj_out_hdr;
    logic         trn_out_valid;
    routed_hdr_t  trn_out_hdr;

    integer       seed;
    int           errors;
    int           inj_port_hits [P];
    int           trn_local_hits;
    int           trn_remote_hits;

    logic         exp_inj_valid;            // due at the coming negedge
    routed_hdr_t  exp_inj_hdr;
    logic         exp_trn_valid;
    routed_hdr_t  exp_trn_hdr;
    logic         nxt_inj_valid;            // for the inputs just driven
    routed_hdr_t  nxt_inj_hdr;
    logic         nxt_trn_valid;
    routed_hdr_t  nxt_trn_hdr;

    tb_clock_gen i_clock_gen (
        .clk  (clk),
        .reset(reset)
    );

    mesh_route_unit #(
        .ROUTER_ADDR(ROUTER_ADDR)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .inj_valid    (inj_valid),
        .inj_hdr      (inj_hdr),
        .trn_valid    (trn_valid),
        .trn_hdr      (trn_hdr),
        .inj_out_valid(inj_out_valid),
        .inj_out_hdr  (inj_out_hdr),
        .trn_out_valid(trn_out_valid),
        .trn_out_hdr  (trn_out_hdr)
    );

    // XY rule on integers, address bits are {l, y[1:0], x[1:0]}
    function automatic port_e model_route(int cx, int cy, e_addr_t addr);
        int dx;
        int dy;
        dx = int'(addr[1:0]);
        dy = int'(addr[3:2]);
        if (dx > cx) return PORT_EAST;
        if (dx < cx) return PORT_WEST;
        if (dy < cy) return PORT_NORTH;
        if (dy > cy) return PORT_SOUTH;
        return addr[4] ? PORT_LOCAL1 : PORT_LOCAL0;
    endfunction

    function automatic port_e model_look_ahead(port_e dp, e_addr_t addr);
        int nx;
        int ny;
        nx = CUR_X;
        ny = CUR_Y;
        case (dp)
            PORT_EAST:  nx = nx + 1;
            PORT_WEST:  nx = nx - 1;
            PORT_NORTH: ny = ny - 1;            // y grows southwards
            PORT_SOUTH: ny = ny + 1;
            default:    return dp;              // local destport kept
        endcase
        return model_route(nx, ny, addr);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors = errors + 1;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("Something failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic wait_reset_release();
        int count;
        count = 0;
        do begin
            @(negedge clk);
            count = count + 1;
        end while (reset !== 1'b0 && count < RESET_TIMEOUT);
        if (reset !== 1'b0) begin
            $display("timeout: reset was never released");
            $display("Something failed");
            $fatal(1, "reset wait timed out");
        end
    endtask

    task automatic drive_random();
        logic [31:0] rnd;
        logic [15:0] dp_idx;
        logic        v_inj;
        logic        v_trn;
        e_addr_t     inj_addr;
        e_addr_t     trn_addr;
        port_e       dp;
        rnd      = $random(seed);
        v_inj    = rnd[0] | rnd[1];             // busy about 3 cycles in 4
        v_trn    = rnd[2] | rnd[3];
        rnd      = $random(seed);
        inj_addr = rnd[4:0];
        trn_addr = rnd[12:8];
        dp_idx   = rnd[31:16] % 16'd6;
        dp       = port_e'(dp_idx[2:0]);
        inj_valid         <= v_inj;
        inj_hdr.dest_addr <= inj_addr;
        trn_valid         <= v_trn;
        trn_hdr.dest_addr <= trn_addr;
        trn_hdr.destport  <= dp;
        nxt_inj_valid         = v_inj;
        nxt_inj_hdr.dest_addr = inj_addr;
        nxt_inj_hdr.port      = model_route(CUR_X, CUR_Y, inj_addr);
        nxt_trn_valid         = v_trn;
        nxt_trn_hdr.dest_addr = trn_addr;
        nxt_trn_hdr.port      = model_look_ahead(dp, trn_addr);
        if (v_inj) begin
            inj_port_hits[int'(nxt_inj_hdr.port)]++;
        end
        if (v_trn && (dp == PORT_LOCAL0 || dp == PORT_LOCAL1)) begin
            trn_local_hits++;
        end else if (v_trn) begin
            trn_remote_hits++;
        end
    endtask

    task automatic drive_idle();
        inj_valid     <= 1'b0;
        trn_valid     <= 1'b0;
        nxt_inj_valid  = 1'b0;
        nxt_trn_valid  = 1'b0;
    endtask

    task automatic check_outputs();
        check_value("inj_out_valid", 32'(inj_out_valid), 32'(exp_inj_valid));
        check_value("trn_out_valid", 32'(trn_out_valid), 32'(exp_trn_valid));
        if (exp_inj_valid) begin
            check_value("inj_out_hdr.dest_addr", 32'(inj_out_hdr.dest_addr),
                        32'(exp_inj_hdr.dest_addr));
            check_value("inj_out_hdr.port", 32'(inj_out_hdr.port), 32'(exp_inj_hdr.port));
        end
        if (exp_trn_valid) begin
            check_value("trn_out_hdr.dest_addr", 32'(trn_out_hdr.dest_addr),
                        32'(exp_trn_hdr.dest_addr));
            check_value("trn_out_hdr.port", 32'(trn_out_hdr.port), 32'(exp_trn_hdr.port));
        end
    endtask

    initial begin
        seed            = 94;
        errors          = 0;
        trn_local_hits  = 0;
        trn_remote_hits = 0;
        for (int i = 0; i < P; i++) begin
            inj_port_hits[i] = 0;
        end
        inj_valid     <= 1'b1;                  // held high through reset
        inj_hdr       <= '0;
        trn_valid     <= 1'b1;
        trn_hdr       <= '0;
        exp_inj_valid  = 1'b0;
        exp_inj_hdr    = '0;
        exp_trn_valid  = 1'b0;
        exp_trn_hdr    = '0;

        wait_reset_release();
        check_value("inj_out_valid", 32'(inj_out_valid), 32'd0);   // first cycle after reset
        check_value("trn_out_valid", 32'(trn_out_valid), 32'd0);

        // held headers are taken at the first edge after reset
        exp_inj_valid         = 1'b1;
        exp_inj_hdr.dest_addr = '0;
        exp_inj_hdr.port      = model_route(CUR_X, CUR_Y, '0);
        exp_trn_valid         = 1'b1;
        exp_trn_hdr.dest_addr = '0;
        exp_trn_hdr.port      = model_look_ahead(PORT_LOCAL0, '0);

        for (int cyc = 0; cyc < IDLE_CYCLES + NUM_CYCLES + 1; cyc++) begin
            @(posedge clk);
            if (cyc >= IDLE_CYCLES && cyc < IDLE_CYCLES + NUM_CYCLES) begin
                drive_random();
            end else begin
                drive_idle();
            end
            @(negedge clk);
            check_outputs();                    // headers driven one edge earlier
            exp_inj_valid = nxt_inj_valid;
            exp_inj_hdr   = nxt_inj_hdr;
            exp_trn_valid = nxt_trn_valid;
            exp_trn_hdr   = nxt_trn_hdr;
        end

        for (int i = 0; i < P; i++) begin
            if (inj_port_hits[i] == 0) begin
                $display("injected headers never took port %0d", i);
                errors++;
            end
        end
        if (trn_local_hits == 0 || trn_remote_hits == 0) begin
            $display("transit headers missed local or neighbor destports");
            errors++;
        end

        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "%0d errors found", errors);
        end
    end

endmodule

// File: flist.f
source/noc_geom_pkg.sv
source/route_pkg.sv
source/xy_route_decide.sv
source/next_router_select.sv
source/look_ahead_route.sv
source/inject_route.sv
source/mesh_route_unit.sv
testbench/tb_clock_gen.sv
testbench/mesh_route_unit_checker.sv
testbench/mesh_route_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mesh routing unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=mesh_route_unit_tb

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
